// File: design/mc_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// I/O row configuration constants
// Row geometry, word widths and the length of the configuration phase
// shared by every block of the row.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package mc_cfg_pkg;

  // column coordinate, up to 8 columns
  localparam int x_cord_width_c = 3;

  // word address inside one column memory
  localparam int addr_width_c = 4;

  localparam int data_width_c = 32;

  // cycles of configuration before the done flag
  localparam int cfg_cycles_c = 8;

endpackage

`default_nettype wire

// File: design/mc_packet_pkg.sv
//////////////////////////////////////////////////////////////////////
// I/O row packet types
// Memory opcode plus the request and response packets carried on
// every link of the row.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package mc_packet_pkg;

  import mc_cfg_pkg::*;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } mem_op_e;

  // 40 bit request
  typedef struct packed {
    mem_op_e                   op;
    logic [x_cord_width_c-1:0] x_cord;
    logic [addr_width_c-1:0]   addr;
    logic [data_width_c-1:0]   data;
  } req_pkt_s;

  // 36 bit response
  typedef struct packed {
    logic [x_cord_width_c-1:0] src_x;
    logic [data_width_c-1:0]   data;
    logic                      op;
  } resp_pkt_s;

endpackage

`default_nettype wire

// File: design/io_link_if.sv
//////////////////////////////////////////////////////////////////////
// I/O link
// Valid/ready request channel in one direction and a valid/ready
// response channel coming back.
//////////////////////////////////////////////////////////////////////

`default_nettype none

interface io_link_if
  import mc_packet_pkg::*;
();

  // request channel flowing downstream
  logic      req_v;
  logic      req_ready;
  req_pkt_s  req;

  // response channel flowing back upstream
  logic      resp_v;
  logic      resp_ready;
  resp_pkt_s resp;

  modport up (
    output req_v, req, resp_ready,
    input  req_ready, resp_v, resp
  );

  modport down (
    input  req_v, req, resp_ready,
    output req_ready, resp_v, resp
  );

endinterface

`default_nettype wire

// File: design/reset_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Reset sequencer
// Counts out the configuration phase, raises the done flag and then
// releases core reset through a chain of flops.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module reset_sequencer
  import mc_cfg_pkg::*;
#(
  parameter int reset_depth_p = 3
) (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic cfg_done_o,
  output logic core_rst_o
);

  localparam int cnt_width_lp = $clog2(cfg_cycles_c + 1);

  logic [cnt_width_lp-1:0]  cnt_r;
  logic [reset_depth_p-1:0] rst_chain_r;

  // configuration countdown
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_r <= cnt_width_lp'(cfg_cycles_c);
    end else if (cnt_r != '0) begin
      cnt_r <= cnt_r - 1'b1;
    end
  end

  assign cfg_done_o = (cnt_r == '0);

  // core reset held until done has walked through every stage
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_chain_r <= '1;
    end else begin
      rst_chain_r <= reset_depth_p'({rst_chain_r, ~cfg_done_o});
    end
  end

  assign core_rst_o = rst_chain_r[reset_depth_p-1];

endmodule

`default_nettype wire

// File: design/io_router_node.sv
//////////////////////////////////////////////////////////////////////
// I/O row router node
// Steers requests from the west to the local column or further east,
// and merges local and east responses into one west-bound register.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module io_router_node
  import mc_cfg_pkg::*;
  import mc_packet_pkg::*;
#(
  parameter int num_cols_p = 4
) (
  input  logic                      clk_i,
  input  logic                      core_rst_i,
  input  logic [x_cord_width_c-1:0] my_x_i,
  io_link_if.down                   west,
  io_link_if.up                     east,
  io_link_if.up                     proc
);

  // row must fit the coordinate field
  if (num_cols_p < 2 || num_cols_p > (1 << x_cord_width_c)) begin : g_bad_cols
    $error("num_cols_p out of range for x_cord_width_c");
  end

  logic      run_r;
  logic      to_proc;
  logic      east_free;
  logic      proc_free;
  logic      west_free;
  logic      take_east;
  logic      take_proc;
  logic      grant_proc;
  logic      grant_east;
  logic      prio_east_r;
  logic      east_req_v_r;
  logic      proc_req_v_r;
  logic      west_resp_v_r;
  req_pkt_s  east_req_r;
  req_pkt_s  proc_req_r;
  resp_pkt_s west_resp_r;

  //////////////////////////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////////////////////////
  assign to_proc        = (west.req.x_cord == my_x_i);
  assign east_free      = ~east_req_v_r | east.req_ready;
  assign proc_free      = ~proc_req_v_r | proc.req_ready;
  assign west.req_ready = run_r & (to_proc ? proc_free : east_free);
  assign take_proc      = west.req_v & west.req_ready & to_proc;
  assign take_east      = west.req_v & west.req_ready & ~to_proc;

  //////////////////////////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////////////////////////
  assign west_free  = ~west_resp_v_r | west.resp_ready;
  // round robin, priority flips after each grant
  assign grant_proc = run_r & west_free & proc.resp_v & (~east.resp_v | ~prio_east_r);
  assign grant_east = run_r & west_free & east.resp_v & ~grant_proc;

  assign proc.resp_ready = grant_proc;
  assign east.resp_ready = grant_east;

  always_ff @(posedge clk_i) begin
    if (core_rst_i) begin
      run_r         <= 1'b0;
      east_req_v_r  <= 1'b0;
      proc_req_v_r  <= 1'b0;
      west_resp_v_r <= 1'b0;
      prio_east_r   <= 1'b0;
    end else begin
      run_r <= 1'b1;
      if (east_free) begin
        east_req_v_r <= take_east;
      end
      if (proc_free) begin
        proc_req_v_r <= take_proc;
      end
      if (west_free) begin
        west_resp_v_r <= grant_proc | grant_east;
      end
      if (grant_proc | grant_east) begin
        prio_east_r <= grant_proc;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_east) begin
      east_req_r <= west.req;
    end
    if (take_proc) begin
      proc_req_r <= west.req;
    end
    if (grant_proc) begin
      west_resp_r <= proc.resp;
    end else if (grant_east) begin
      west_resp_r <= east.resp;
    end
  end

  assign east.req_v  = east_req_v_r;
  assign east.req    = east_req_r;
  assign proc.req_v  = proc_req_v_r;
  assign proc.req    = proc_req_r;
  assign west.resp_v = west_resp_v_r;
  assign west.resp   = west_resp_r;

endmodule

`default_nettype wire

// File: design/column_test_mem.sv
//////////////////////////////////////////////////////////////////////
// Column test memory
// Word memory under one router node; answers loads and stores with a
// single registered response.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module column_test_mem
  import mc_cfg_pkg::*;
  import mc_packet_pkg::*;
#(
  parameter int mem_words_p = 16
) (
  input  logic                      clk_i,
  input  logic                      core_rst_i,
  input  logic [x_cord_width_c-1:0] src_x_i,
  io_link_if.down                   link
);

  if (mem_words_p < 1 || mem_words_p > (1 << addr_width_c)) begin : g_bad_words
    $error("mem_words_p does not fit addr_width_c");
  end

  logic [data_width_c-1:0] mem_r [mem_words_p];
  logic                    resp_v_r;
  resp_pkt_s               resp_r;
  logic                    accept;
  logic                    is_store;

  // take a new request when the response slot is empty or draining
  assign link.req_ready = ~resp_v_r | link.resp_ready;
  assign accept         = link.req_v & link.req_ready;
  assign is_store       = (link.req.op == op_store);

  always_ff @(posedge clk_i) begin
    if (core_rst_i) begin
      resp_v_r <= 1'b0;
      for (int i = 0; i < mem_words_p; i++) begin
        mem_r[i] <= '0;
      end
    end else begin
      if (link.req_ready) begin
        resp_v_r <= link.req_v;
      end
      if (accept && is_store) begin
        mem_r[link.req.addr] <= link.req.data;
      end
    end
  end

  // store echoes its data, load returns the old word
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_r.src_x <= src_x_i;
      resp_r.op    <= link.req.op;
      resp_r.data  <= is_store ? link.req.data : mem_r[link.req.addr];
    end
  end

  assign link.resp_v = resp_v_r;
  assign link.resp   = resp_r;

endmodule

`default_nettype wire

// File: design/io_row_top.sv
//////////////////////////////////////////////////////////////////////
// I/O row top level
// Reset sequencer, a west-to-east chain of router nodes with one test
// memory per column, host link on the west end.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module io_row_top
  import mc_cfg_pkg::*;
  import mc_packet_pkg::*;
#(
  parameter int num_cols_p    = 4,
  parameter int reset_depth_p = 3,
  parameter int mem_words_p   = 16
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      host_req_v_i,
  output logic                      host_req_ready_o,
  input  mem_op_e                   host_req_op_i,
  input  logic [x_cord_width_c-1:0] host_req_x_i,
  input  logic [addr_width_c-1:0]   host_req_addr_i,
  input  logic [data_width_c-1:0]   host_req_data_i,
  output logic                      host_resp_v_o,
  input  logic                      host_resp_ready_i,
  output logic [x_cord_width_c-1:0] host_resp_src_x_o,
  output logic [data_width_c-1:0]   host_resp_data_o,
  output logic                      host_resp_op_o,
  output logic                      cfg_done_o
);

  logic core_rst;

  // row_link[x] is the west link of node x
  io_link_if row_link [num_cols_p+1] ();
  io_link_if mem_link [num_cols_p] ();

  reset_sequencer #(
    .reset_depth_p(reset_depth_p)
  ) rst_seq (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cfg_done_o (cfg_done_o),
    .core_rst_o (core_rst)
  );

  for (genvar x = 0; x < num_cols_p; x++) begin : g_col
    io_router_node #(
      .num_cols_p(num_cols_p)
    ) io_rtr (
      .clk_i      (clk_i),
      .core_rst_i (core_rst),
      .my_x_i     (x_cord_width_c'(x)),
      .west       (row_link[x]),
      .east       (row_link[x+1]),
      .proc       (mem_link[x])
    );

    column_test_mem #(
      .mem_words_p(mem_words_p)
    ) test_mem (
      .clk_i      (clk_i),
      .core_rst_i (core_rst),
      .src_x_i    (x_cord_width_c'(x)),
      .link       (mem_link[x])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // host link and east end
  //////////////////////////////////////////////////////////////////////
  assign row_link[0].req_v = host_req_v_i;
  assign row_link[0].req   = '{op: host_req_op_i, x_cord: host_req_x_i,
                               addr: host_req_addr_i, data: host_req_data_i};
  assign row_link[0].resp_ready = host_resp_ready_i;

  assign host_req_ready_o  = row_link[0].req_ready;
  assign host_resp_v_o     = row_link[0].resp_v;
  assign host_resp_src_x_o = row_link[0].resp.src_x;
  assign host_resp_data_o  = row_link[0].resp.data;
  assign host_resp_op_o    = row_link[0].resp.op;

  // nothing lives past the last column
  assign row_link[num_cols_p].req_ready = 1'b0;
  assign row_link[num_cols_p].resp_v    = 1'b0;
  assign row_link[num_cols_p].resp      = '0;

endmodule

`default_nettype wire

// File: test/io_row_assertions.sv
//////////////////////////////////////////////////////////////////////
// I/O row host port assertions
// Bound into the row top level; watches the host response handshake
// and the host request ready against the configuration done flag.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module io_row_assertions
  import mc_cfg_pkg::*;
(
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      req_ready_i,
  input logic                      cfg_done_i,
  input logic                      resp_v_i,
  input logic                      resp_ready_i,
  input logic [x_cord_width_c-1:0] resp_src_x_i,
  input logic [data_width_c-1:0]   resp_data_i,
  input logic                      resp_op_i
);

  int fail_cnt = 0;

  // pending response stays put until taken
  resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_i && !resp_ready_i |=> resp_v_i && $stable(resp_data_i)
      && $stable(resp_src_x_i) && $stable(resp_op_i))
    else begin
      fail_cnt++;
      $error("host response dropped or changed before it was taken");
    end

  ready_after_cfg: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_ready_i |-> cfg_done_i)
    else begin
      fail_cnt++;
      $error("host request ready high before configuration done");
    end

endmodule

bind io_row_top io_row_assertions row_assert (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_ready_i  (host_req_ready_o),
  .cfg_done_i   (cfg_done_o),
  .resp_v_i     (host_resp_v_o),
  .resp_ready_i (host_resp_ready_i),
  .resp_src_x_i (host_resp_src_x_o),
  .resp_data_i  (host_resp_data_o),
  .resp_op_i    (host_resp_op_o)
);

`default_nettype wire

// File: test/io_row_tb.sv
//////////////////////////////////////////////////////////////////////
// I/O row testbench
// Random host traffic against a shadow memory model per column, with
// response back-pressure, a mid-run reset and a cycle timeout.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module io_row_tb
  import mc_cfg_pkg::*;
  import mc_packet_pkg::*;
();

  localparam int num_cols_lp    = 4;
  localparam int reset_depth_lp = 3;
  localparam int mem_words_lp   = 16;
  localparam int num_reqs_lp    = num_cols_lp + 300 + 16 + num_cols_lp * mem_words_lp;
  localparam int timeout_lp     = 40 * num_reqs_lp + 200;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      host_req_v_i;
  logic                      host_req_ready_o;
  mem_op_e                   host_req_op_i;
  logic [x_cord_width_c-1:0] host_req_x_i;
  logic [addr_width_c-1:0]   host_req_addr_i;
  logic [data_width_c-1:0]   host_req_data_i;
  logic                      host_resp_v_o;
  logic                      host_resp_ready_i;
  logic [x_cord_width_c-1:0] host_resp_src_x_o;
  logic [data_width_c-1:0]   host_resp_data_o;
  logic                      host_resp_op_o;
  logic                      cfg_done_o;

  // shadow words per column
  logic [data_width_c-1:0] shadow [1 << x_cord_width_c][1 << addr_width_c];
  // expected responses in send order
  resp_pkt_s               exp_q [$];

  string test_name = "reset";
  logic  bp_en = 1'b0;
  int    check_cnt = 0;
  int    err_cnt = 0;
  int    other_cnt = 0;
  int    cycle_cnt = 0;

  io_row_top #(
    .num_cols_p    (num_cols_lp),
    .reset_depth_p (reset_depth_lp),
    .mem_words_p   (mem_words_lp)
  ) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_resp(input resp_pkt_s exp, input resp_pkt_s act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Error %s: expected src_x=%0d data=%h op=%0d, actual src_x=%0d data=%h op=%0d",
               test_name, exp.src_x, exp.data, exp.op, act.src_x, act.data, act.op);
    end
  endtask

  task automatic check_status(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Error %s %s: expected %b, actual %b", test_name, name, exp, act);
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             check_cnt, err_cnt, other_cnt, DUT.row_assert.fail_cnt);
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    exp_q.delete();
    foreach (shadow[x, a]) begin
      shadow[x][a] = '0;
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
  endtask

  // done must show up no later than the first host ready
  task automatic wait_ready();
    logic done_seen;
    done_seen = 1'b0;
    check_status("cfg_done low after reset", 1'b0, cfg_done_o);
    do begin
      @(negedge clk_i);
      if (cfg_done_o) begin
        done_seen = 1'b1;
      end
    end while (!host_req_ready_o);
    check_status("cfg_done before host ready", 1'b1, done_seen);
    @(posedge clk_i);
    #1;
  endtask

  task automatic send_req(input req_pkt_s pkt);
    resp_pkt_s exp;
    host_req_v_i    = 1'b1;
    host_req_op_i   = pkt.op;
    host_req_x_i    = pkt.x_cord;
    host_req_addr_i = pkt.addr;
    host_req_data_i = pkt.data;
    do @(negedge clk_i); while (!host_req_ready_o);
    check_status("cfg_done at request accept", 1'b1, cfg_done_o);
    exp.src_x = pkt.x_cord;
    exp.op    = pkt.op;
    if (pkt.op == op_store) begin
      shadow[pkt.x_cord][pkt.addr] = pkt.data;
      exp.data = pkt.data;
    end else begin
      exp.data = shadow[pkt.x_cord][pkt.addr];
    end
    exp_q.push_back(exp);
    @(posedge clk_i);
    #1;
    host_req_v_i = 1'b0;
  endtask

  function automatic req_pkt_s make_req(input logic is_store, input int x, input int a);
    req_pkt_s pkt;
    pkt.op     = is_store ? op_store : op_load;
    pkt.x_cord = x_cord_width_c'(x);
    pkt.addr   = addr_width_c'(a);
    pkt.data   = $urandom;
    return pkt;
  endfunction

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  // response monitor sampling at the falling edge
  initial begin : resp_monitor
    resp_pkt_s act;
    int        idx;
    forever begin
      @(negedge clk_i);
      if (host_resp_v_o && host_resp_ready_i) begin
        act.src_x = host_resp_src_x_o;
        act.data  = host_resp_data_o;
        act.op    = host_resp_op_o;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
          if (idx < 0 && exp_q[i].src_x == act.src_x) begin
            idx = i;
          end
        end
        if (idx < 0) begin
          other_cnt++;
          $display("%s: response from column %0d that nothing was waiting for",
                   test_name, act.src_x);
        end else begin
          check_resp(exp_q[idx], act);
          exp_q.delete(idx);
        end
      end
    end
  end

  initial begin : resp_throttle
    host_resp_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      host_resp_ready_i = bp_en ? ($urandom % 4 != 0) : 1'b1;
    end
  end

  initial begin : watchdog
    while (cycle_cnt < timeout_lp) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("run timed out after %0d cycles in %s", cycle_cnt, test_name);
    report_counts();
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main_seq
    rst_n_i         = 1'b0;
    host_req_v_i    = 1'b0;
    host_req_op_i   = op_load;
    host_req_x_i    = '0;
    host_req_addr_i = '0;
    host_req_data_i = '0;
    void'($urandom(54566));
    apply_reset();
    wait_ready();

    test_name = "zero_load";
    for (int x = 0; x < num_cols_lp; x++) begin
      send_req(make_req(1'b0, x, $urandom % mem_words_lp));
    end
    wait_drain();

    // random traffic under response back-pressure
    test_name = "random_mix";
    bp_en = 1'b1;
    repeat (300) begin
      send_req(make_req($urandom % 2 == 1, $urandom % num_cols_lp, $urandom % mem_words_lp));
    end
    wait_drain();

    test_name = "far_near";
    for (int i = 0; i < 16; i++) begin
      send_req(make_req(i < 8, (i % 2 == 0) ? num_cols_lp - 1 : 0, (i / 2) % mem_words_lp));
    end
    wait_drain();

    test_name = "mid_reset";
    bp_en = 1'b0;
    apply_reset();
    wait_ready();
    for (int x = 0; x < num_cols_lp; x++) begin
      for (int a = 0; a < mem_words_lp; a++) begin
        send_req(make_req(1'b0, x, a));
      end
    end
    wait_drain();

    report_counts();
    if (err_cnt == 0 && other_cnt == 0 && DUT.row_assert.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
design/mc_cfg_pkg.sv
design/mc_packet_pkg.sv
design/io_link_if.sv
design/reset_sequencer.sv
design/io_router_node.sv
design/column_test_mem.sv
design/io_row_top.sv
test/io_row_assertions.sv
test/io_row_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the I/O row testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module io_row_tb -Mdir obj_dir

# keep going past assertion errors so the testbench can report them
./obj_dir/Vio_row_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
